/* vlog.f */
+incdir+test
logic/proc_pkg.sv
logic/proc_decoder.sv
logic/proc_regfile.sv
logic/proc_alu.sv
logic/proc_control.sv
logic/proc_top.sv
test/proc_tb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - files:
      - logic/proc_pkg.sv
      - logic/proc_decoder.sv
      - logic/proc_regfile.sv
      - logic/proc_alu.sv
      - logic/proc_control.sv
      - logic/proc_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/proc_tb.sv

/* test/proc_ref.svh */
// instruction-set model over ref_mem and exp_q of the including testbench; word accesses below 2048
`ifndef proc_ref_svh
`define proc_ref_svh

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: r = (a < b) ? 32'd1 : 32'd0;
        3'd4: r = a ^ b;
        3'd5: r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// runs the image until a halt store or an illegal word, returns the instructions executed
function automatic int ref_run();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] nxt;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        taken;
    bit          done;
    int          steps;
    foreach (x[i]) x[i] = '0;
    pc = '0;
    done = 0;
    steps = 0;
    while (!done && steps < 20000) begin
        ins   = ref_mem[pc[10:2]];
        rd    = ins[11:7];
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        steps++;
        case (ins[6:0])
            7'h13: begin
                if ((f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    done = 1;
                end else begin
                    x[rd] = ref_alu(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
                end
            end
            7'h33: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    x[rd] = ref_alu(f3, f7 == 7'h20, a, b);
                end else begin
                    done = 1;
                end
            end
            7'h37: x[rd] = {ins[31:12], 12'b0};
            7'h17: x[rd] = pc + {ins[31:12], 12'b0};
            7'h6f: begin
                x[rd] = pc + 32'd4;
                nxt   = pc + imm_j;
            end
            7'h67: begin
                if (f3 != 3'd0) begin
                    done = 1;
                end else begin
                    // target before link, rd may equal rs1
                    nxt   = (a + imm_i) & ~32'd1;
                    x[rd] = pc + 32'd4;
                end
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    done = 1;
                end else if (taken) begin
                    nxt = pc + imm_b;
                end
            end
            7'h03: begin
                addr = a + imm_i;
                if (f3 != 3'd2) done = 1;
                else x[rd] = ref_mem[addr[10:2]];
            end
            7'h23: begin
                addr = a + imm_s;
                if (f3 != 3'd2 || addr == halt_addr) done = 1;
                else if (addr == out_addr) exp_q.push_back(b);
                else ref_mem[addr[10:2]] = b;
            end
            default: done = 1;
        endcase
        x[0] = '0;
        pc = nxt;
    end
    return steps;
endfunction

`endif

/* test/proc_tb.sv */
// single core with a 512-word memory model; programs stay below byte address 2048
module proc_tb import proc_pkg::*; ();

    localparam logic [31:0] out_addr  = 32'd1000;
    localparam logic [31:0] halt_addr = 32'd1004;

    logic        clk;
    logic        rst;
    mem_req_t    mem_req;
    logic [31:0] mem_rd_data;
    logic        mem_ack;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    logic [31:0] mem [512];
    logic [31:0] ref_mem [512];
    logic [31:0] exp_q [$];
    int          seed = 32'hf5df_4431;
    int          prog_len;
    int          out_idx;
    int          budget;
    int          cycles;
    bit          running;
    string       test_name;

    // memory model state
    bit          busy;
    int          wait_cnt;
    mem_req_t    cur_req;

    `include "proc_ref.svh"

    proc_top #(
        .reset_pc  (32'd0),
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) proc_top_i (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    // answers each request after 1 to 4 cycles
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wait_cnt <= 1) begin
                mem_ack <= 1'b1;
                busy    <= 1'b0;
                if (cur_req.wr) mem[cur_req.addr[10:2]] <= cur_req.wr_data;
                else mem_rd_data <= mem[cur_req.addr[10:2]];
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_req.rd || mem_req.wr) begin
            busy     <= 1'b1;
            cur_req  <= mem_req;
            wait_cnt <= 1 + ($unsigned($random(seed)) % 4);
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (out_idx >= exp_q.size()) begin
                fail_run($sformatf("test %s produced more outputs than expected", test_name));
            end else begin
                check_value(test_name, exp_q[out_idx], out_data);
                out_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > budget) begin
                fail_run($sformatf("halt did not rise within %0d cycles in test %s",
                                   budget, test_name));
            end
        end
    end

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic new_program();
        prog_len = 0;
        // fill depends on every address bit
        for (int i = 0; i < 512; i++) mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endtask

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_out(input logic [4:0] r);
        emit(enc_s(out_addr[11:0], r, 5'd0));
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = (val + 32'h800) >> 12;
        emit({upper[19:0], rd, 7'h37});
        emit(enc_i(val[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic run_program(input string name);
        int steps;
        for (int i = 0; i < 512; i++) ref_mem[i] = mem[i];
        exp_q.delete();
        steps     = ref_run();
        test_name = name;
        out_idx   = 0;
        budget    = steps * 10 + 60;
        cycles    = 0;
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        running <= 1'b1;
        @(posedge clk);
        // quiet outputs until the first instruction word comes back
        while (!mem_ack) begin
            check_value({name, " reset out_valid"}, 32'd0, {31'd0, out_valid});
            check_value({name, " reset halt"}, 32'd0, {31'd0, halt});
            check_value({name, " reset write"}, 32'd0, {31'd0, mem_req.wr});
            if (mem_req.rd) begin
                check_value({name, " first fetch"}, 32'd0, mem_req.addr);
            end
            @(posedge clk);
        end
        while (!halt) @(posedge clk);
        running <= 1'b0;
        check_value({name, " output count"}, exp_q.size(), out_idx);
        repeat (20) begin
            @(posedge clk);
            if (mem_req.rd || mem_req.wr) fail_run({"request issued after halt in ", name});
        end
        for (int i = 0; i < 512; i++) check_value({name, " memory"}, ref_mem[i], mem[i]);
    endtask

    initial begin
        logic [31:0] v;
        int          loop_pc;
        int          br_f3 [6];
        clk         = 1'b0;
        rst         = 1'b1;
        mem_rd_data = '0;
        mem_ack     = 1'b0;
        running     = 1'b0;
        busy        = 1'b0;
        out_idx     = 0;
        test_name   = "reset";
        br_f3       = '{0, 1, 4, 5, 6, 7};

        // every OP and OP-IMM function on random operands
        new_program();
        repeat (2) begin
            load_const(5'd1, $random(seed));
            load_const(5'd2, $random(seed));
            for (int f = 0; f < 8; f++) begin
                emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
                emit_out(5'd3);
                v = $random(seed);
                if (f == 1 || f == 5) v[11:5] = 7'h00;
                emit(enc_i(v[11:0], 5'd1, f[2:0], 5'd3, 7'h13));
                emit_out(5'd3);
            end
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
            emit_out(5'd3);
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
            emit_out(5'd3);
            v = $random(seed) & 31;
            emit(enc_i({7'h20, v[4:0]}, 5'd1, 3'd5, 5'd3, 7'h13));
            emit_out(5'd3);
        end
        emit(enc_s(halt_addr[11:0], 5'd0, 5'd0));
        run_program("alu");

        // countdown loop, every branch kind, jal and jalr
        new_program();
        emit(enc_i(12'd3 + ($unsigned($random(seed)) % 4), 5'd0, 3'd0, 5'd1, 7'h13));
        loop_pc = prog_len * 4;
        emit_out(5'd1);
        emit(enc_i(12'd1, 5'd2, 3'd0, 5'd2, 7'h13));
        emit(enc_i(12'hfff, 5'd1, 3'd0, 5'd1, 7'h13));
        emit(enc_b(13'(loop_pc - prog_len * 4), 5'd0, 5'd1, 3'd1));
        for (int pass = 0; pass < 2; pass++) begin
            load_const(5'd5, $random(seed));
            if (pass == 0) load_const(5'd6, $random(seed));
            else emit(enc_i(12'd0, 5'd5, 3'd0, 5'd6, 7'h13));
            foreach (br_f3[k]) begin
                emit(enc_b(13'd12, 5'd6, 5'd5, 3'(br_f3[k])));
                emit(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));
                emit(enc_j(21'd8, 5'd0));
                emit(enc_i(12'd2, 5'd0, 3'd0, 5'd7, 7'h13));
                emit_out(5'd7);
            end
        end
        emit(enc_j(21'd8, 5'd8));
        emit_out(5'd0);
        emit_out(5'd8);
        emit({20'd0, 5'd10, 7'h17});
        emit(enc_i(12'd17, 5'd10, 3'd0, 5'd10, 7'h13));
        emit(enc_i(12'd0, 5'd10, 3'd0, 5'd11, 7'h67));
        emit_out(5'd0);
        emit_out(5'd11);
        emit_out(5'd2);
        emit(enc_s(halt_addr[11:0], 5'd0, 5'd0));
        run_program("control");

        // stores and loads around byte address 1024
        new_program();
        emit(enc_i(12'd1024, 5'd0, 3'd0, 5'd20, 7'h13));
        emit(enc_i(12'd1200, 5'd0, 3'd0, 5'd21, 7'h13));
        for (int i = 0; i < 6; i++) begin
            load_const(5'd1, $random(seed));
            emit(enc_s(12'(i * 4), 5'd1, 5'd20));
        end
        for (int i = 0; i < 6; i++) begin
            emit(enc_i(12'(i * 4), 5'd20, 3'd2, 5'd3, 7'h03));
            emit_out(5'd3);
            emit(enc_r(7'h00, 5'd3, 5'd4, 3'd0, 5'd4));
        end
        emit(enc_s(12'hff8, 5'd4, 5'd21));
        emit(enc_i(12'hff8, 5'd21, 3'd2, 5'd5, 7'h03));
        emit_out(5'd5);
        emit(enc_s(halt_addr[11:0], 5'd0, 5'd0));
        run_program("memory");

        new_program();
        repeat (3) begin
            v = $random(seed);
            emit({v[19:0], 5'd1, 7'h37});
            emit_out(5'd1);
            v = $random(seed);
            emit({v[19:0], 5'd2, 7'h17});
            emit_out(5'd2);
        end
        emit(enc_s(halt_addr[11:0], 5'd0, 5'd0));
        run_program("upper");

        // halt through an unknown opcode
        new_program();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
        emit_out(5'd1);
        emit(32'hffff_ffff);
        run_program("illegal");

        $display("TB PASSED");
        $finish;
    end

endmodule

/* logic/proc_top.sv */
// rv32i core top; memory port is shared between fetch and data, out and halt addresses are params
module proc_top import proc_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc  = 32'd0,
    parameter logic [xlen-1:0] out_addr  = 32'd1000,
    parameter logic [xlen-1:0] halt_addr = 32'd1004
) (
    input  logic            clk,
    input  logic            rst,
    output mem_req_t        mem_req,
    input  logic [xlen-1:0] mem_rd_data,
    input  logic            mem_ack,
    output logic [xlen-1:0] out_data,
    output logic            out_valid,
    output logic            halt
);

    decoded_t                 dec;
    logic [xlen-1:0]          rs1_data;
    logic [xlen-1:0]          rs2_data;
    logic [xlen-1:0]          alu_result;
    logic                     take_branch;
    logic [xlen-1:0]          pc;
    logic                     wr_en;
    logic [reg_sel_width-1:0] wr_sel;
    logic [xlen-1:0]          wr_data;

    // the read data bus carries the instruction word in execute
    proc_decoder proc_decoder_i (
        .instr (mem_rd_data),
        .dec   (dec)
    );

    proc_regfile proc_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    proc_alu proc_alu_i (
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    proc_control #(
        .reset_pc  (reset_pc),
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) proc_control_i (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .take_branch (take_branch),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_req     (mem_req),
        .pc          (pc),
        .wr_en       (wr_en),
        .wr_sel      (wr_sel),
        .wr_data     (wr_data),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

endmodule

/* logic/proc_control.sv */
// one outstanding memory request at a time; requests and out_valid are registered, halt needs rst
module proc_control import proc_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc  = 32'd0,
    parameter logic [xlen-1:0] out_addr  = 32'd1000,
    parameter logic [xlen-1:0] halt_addr = 32'd1004
) (
    input  logic                     clk,
    input  logic                     rst,
    input  decoded_t                 dec,
    input  logic [xlen-1:0]          rs1_data,
    input  logic [xlen-1:0]          rs2_data,
    input  logic [xlen-1:0]          alu_result,
    input  logic                     take_branch,
    input  logic [xlen-1:0]          mem_rd_data,
    input  logic                     mem_ack,
    output mem_req_t                 mem_req,
    output logic [xlen-1:0]          pc,
    output logic                     wr_en,
    output logic [reg_sel_width-1:0] wr_sel,
    output logic [xlen-1:0]          wr_data,
    output logic [xlen-1:0]          out_data,
    output logic                     out_valid,
    output logic                     halt
);

    state_e          state;
    state_e          state_n;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_n;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] base;
    logic [xlen-1:0] target;
    decoded_t        dec_q;
    mem_req_t        req_q;
    mem_req_t        req_n;
    logic            fetch_next;
    logic            capture;
    logic            out_valid_q;
    logic            out_valid_n;
    logic [xlen-1:0] out_data_q;
    logic            pending;

    assign pc_plus4 = pc_q + 32'd4;
    // shared adder for memory addresses and jump targets
    assign base   = (dec.opcode == opc_jal || dec.opcode == opc_branch) ? pc_q : rs1_data;
    assign target = base + dec.imm;

    always_comb begin
        state_n     = state;
        pc_n        = pc_q;
        req_n       = '0;
        fetch_next  = 1'b0;
        capture     = 1'b0;
        out_valid_n = 1'b0;
        wr_en       = 1'b0;
        wr_sel      = dec.rd;
        wr_data     = alu_result;
        case (state)
            fetch: begin
                req_n.rd   = 1'b1;
                req_n.addr = pc_q;
                state_n    = execute;
            end
            execute: begin
                // instruction word is on mem_rd_data during the ack
                if (mem_ack) begin
                    capture = 1'b1;
                    if (dec.illegal) begin
                        state_n = halted;
                    end else begin
                        case (dec.opcode)
                            opc_op_imm, opc_op, opc_lui, opc_auipc: begin
                                wr_en      = 1'b1;
                                pc_n       = pc_plus4;
                                fetch_next = 1'b1;
                            end
                            opc_jal: begin
                                wr_en      = 1'b1;
                                pc_n       = target;
                                fetch_next = 1'b1;
                            end
                            opc_jalr: begin
                                wr_en      = 1'b1;
                                pc_n       = {target[xlen-1:1], 1'b0};
                                fetch_next = 1'b1;
                            end
                            opc_branch: begin
                                pc_n       = take_branch ? target : pc_plus4;
                                fetch_next = 1'b1;
                            end
                            opc_load: begin
                                req_n.rd   = 1'b1;
                                req_n.addr = target;
                                state_n    = mem_wait;
                            end
                            opc_store: begin
                                if (target == halt_addr) begin
                                    state_n = halted;
                                end else if (target == out_addr) begin
                                    out_valid_n = 1'b1;
                                    pc_n        = pc_plus4;
                                    fetch_next  = 1'b1;
                                end else begin
                                    req_n.wr      = 1'b1;
                                    req_n.addr    = target;
                                    req_n.wr_data = rs2_data;
                                    state_n       = mem_wait;
                                end
                            end
                            default: state_n = halted;
                        endcase
                    end
                end
            end
            mem_wait: begin
                if (mem_ack) begin
                    if (dec_q.opcode == opc_load) begin
                        wr_en   = 1'b1;
                        wr_sel  = dec_q.rd;
                        wr_data = mem_rd_data;
                    end
                    pc_n       = pc_plus4;
                    fetch_next = 1'b1;
                    state_n    = execute;
                end
            end
            default: ;
        endcase
        if (fetch_next) begin
            req_n.rd   = 1'b1;
            req_n.addr = pc_n;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= fetch;
            pc_q        <= reset_pc;
            req_q       <= '0;
            out_valid_q <= 1'b0;
            pending     <= 1'b0;
        end else begin
            state       <= state_n;
            pc_q        <= pc_n;
            req_q       <= req_n;
            out_valid_q <= out_valid_n;
            pending     <= (pending && !mem_ack) || req_q.rd || req_q.wr;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_q <= dec;
        end
        if (out_valid_n) begin
            out_data_q <= rs2_data;
        end
    end

    assign mem_req   = req_q;
    assign pc        = pc_q;
    assign out_data  = out_data_q;
    assign out_valid = out_valid_q;
    assign halt      = (state == halted);

    a_req_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_req.rd && mem_req.wr)
    );

    // memory must not answer a request that was never made
    a_ack_pending: assert property (
        @(posedge clk) disable iff (rst) mem_ack |-> pending
    );

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (rst) (state == halted) |=> (state == halted)
    );

endmodule

/* logic/proc_alu.sv */
// combinational; result is meaningful for register-writing instructions, take_branch for branches
module proc_alu import proc_pkg::*; (
    input  decoded_t        dec,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result,
    output logic            take_branch
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            cond;

    // auipc adds to the pc, op-imm takes the immediate as second operand
    assign op_a  = (dec.opcode == opc_auipc) ? pc : rs1_data;
    assign op_b  = (dec.opcode == opc_op) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:      result = op_a + op_b;
            alu_sub:      result = op_a - op_b;
            alu_slt:      result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:     result = {31'b0, op_a < op_b};
            alu_xor:      result = op_a ^ op_b;
            alu_or:       result = op_a | op_b;
            alu_and:      result = op_a & op_b;
            alu_sll:      result = op_a << shamt;
            alu_srl:      result = op_a >> shamt;
            alu_sra:      result = $unsigned($signed(op_a) >>> shamt);
            alu_pass_imm: result = dec.imm;
            // return address for jal and jalr
            alu_link:     result = pc + 32'd4;
            default:      result = op_a + op_b;
        endcase
    end

    // branch conditions always compare the two registers
    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = (dec.opcode == opc_branch) && cond;

endmodule

/* logic/proc_regfile.sv */
// 32 x 32 register file; reads are combinational so a write shows up only after the clock edge
module proc_regfile import proc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [reg_sel_width-1:0] rs1_sel,
    input  logic [reg_sel_width-1:0] rs2_sel,
    output logic [xlen-1:0]          rs1_data,
    output logic [xlen-1:0]          rs2_data,
    input  logic                     wr_en,
    input  logic [reg_sel_width-1:0] wr_sel,
    input  logic [xlen-1:0]          wr_data
);

    logic [xlen-1:0] regs [2**reg_sel_width];

    // x0 always reads as zero
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_sel_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // an unknown index here would corrupt an arbitrary register
    a_wr_sel_known: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> !$isunknown(wr_sel)
    );

endmodule

/* logic/proc_decoder.sv */
// purely combinational; unknown opcodes and funct patterns raise illegal, other fields still fill
module proc_decoder import proc_pkg::*; (
    input  logic [xlen-1:0] instr,
    output decoded_t        dec
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [6:0]      funct7;
    logic            f7_zero;
    logic            f7_alt;

    // funct3 to alu function, alt picks sub or sra
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e res;
        case (f3)
            3'b000:  res = alt ? alu_sub : alu_add;
            3'b001:  res = alu_sll;
            3'b010:  res = alu_slt;
            3'b011:  res = alu_sltu;
            3'b100:  res = alu_xor;
            3'b101:  res = alt ? alu_sra : alu_srl;
            3'b110:  res = alu_or;
            default: res = alu_and;
        endcase
        return res;
    endfunction

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign funct7  = instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        dec.opcode  = opcode_e'(instr[6:0]);
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.funct3  = instr[14:12];
        dec.alu_op  = alu_add;
        dec.imm     = imm_i;
        dec.illegal = 1'b0;
        case (dec.opcode)
            opc_op_imm: begin
                // shift immediates reuse funct7 as the shift kind
                dec.alu_op  = funct_to_alu(dec.funct3, f7_alt && dec.funct3 == 3'b101);
                dec.illegal = (dec.funct3 == 3'b001 && !f7_zero) ||
                              (dec.funct3 == 3'b101 && !f7_zero && !f7_alt);
            end
            opc_op: begin
                dec.alu_op  = funct_to_alu(dec.funct3, f7_alt);
                dec.illegal = !(f7_zero ||
                                (f7_alt && (dec.funct3 == 3'b000 || dec.funct3 == 3'b101)));
            end
            opc_lui: begin
                dec.alu_op = alu_pass_imm;
                dec.imm    = imm_u;
            end
            opc_auipc: dec.imm = imm_u;
            opc_jal: begin
                dec.alu_op = alu_link;
                dec.imm    = imm_j;
            end
            opc_jalr: begin
                dec.alu_op  = alu_link;
                dec.illegal = (dec.funct3 != 3'b000);
            end
            opc_branch: begin
                dec.imm     = imm_b;
                dec.illegal = (dec.funct3[2:1] == 2'b01);
            end
            // word access only
            opc_load: dec.illegal = (dec.funct3 != 3'b010);
            opc_store: begin
                dec.imm     = imm_s;
                dec.illegal = (dec.funct3 != 3'b010);
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

/* logic/proc_pkg.sv */
// shared rv32i types; only word loads and stores exist, register and data width fixed at 32
package proc_pkg;

    localparam int xlen          = 32;
    localparam int reg_sel_width = 5;

    // rv32i major opcodes handled by this core
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_imm,
        alu_link
    } alu_op_e;

    typedef enum logic [1:0] {
        fetch,
        execute,
        mem_wait,
        halted
    } state_e;

    // one instruction after decode
    typedef struct packed {
        opcode_e                  opcode;
        logic [reg_sel_width-1:0] rd;
        logic [reg_sel_width-1:0] rs1;
        logic [reg_sel_width-1:0] rs2;
        logic [2:0]               funct3;
        alu_op_e                  alu_op;
        logic [xlen-1:0]          imm;
        logic                     illegal;
    } decoded_t;

    // rd and wr are single-cycle strobes
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wr_data;
        logic            rd;
        logic            wr;
    } mem_req_t;

endpackage
